/* include/spindle_defines.svh */
`ifndef SPINDLE_DEFINES_SVH
`define SPINDLE_DEFINES_SVH

// datapath widths
`define RATE_W        16   // rate sample and channel offset
`define GAIN_W        16   // gain word
`define GAIN_FRAC     8    // gain fraction bits, 256 is unity
`define POT_W         24   // membrane potential accumulator
`define CNT_W         16   // spike counters, wrap on overflow

// input credits held by the sender at reset, also the FIFO depth
`define FIFO_DEPTH    4

// parameter values after reset
`define OFFSET_IA_RST 10
`define OFFSET_II_RST 10
`define GAIN_IA_RST   256  // 1.0
`define GAIN_II_RST   128  // 0.5
`define THRESH_RST    1024

// payload bits carried by a command word
`define CMD_DATA_W    24

`endif

/* src/afferent_pkg.sv */
`include "spindle_defines.svh"

package afferent_pkg;

    // command opcodes for the parameter port
    typedef enum logic [2:0] {
        OP_NOP       = 3'd0,
        OP_OFFSET_IA = 3'd1,
        OP_GAIN_IA   = 3'd2,
        OP_OFFSET_II = 3'd3,
        OP_GAIN_II   = 3'd4,
        OP_THRESH    = 3'd5,
        OP_CLEAR     = 3'd6   // zero potentials and counts
    } afferent_op_e;

    typedef struct packed {
        afferent_op_e            op;
        logic [`CMD_DATA_W-1:0]  data;   // low bits used for offset / gain
    } param_cmd_t;

    typedef struct packed {
        logic [`RATE_W-1:0] rate_ia;
        logic [`RATE_W-1:0] rate_ii;
    } rate_sample_t;

    typedef struct packed {
        logic [`RATE_W-1:0] offset;
        logic [`GAIN_W-1:0] gain;     // unsigned, `GAIN_FRAC fraction bits
    } chan_param_t;

    typedef struct packed {
        logic              spike_ia;
        logic              spike_ii;
        logic [`CNT_W-1:0] count_ia;  // count including this event
        logic [`CNT_W-1:0] count_ii;
    } spike_event_t;

endpackage

/* src/param_regs.sv */
`timescale 1ns/1ps
`include "spindle_defines.svh"

module param_regs
    import afferent_pkg::*;
(
    input  logic              ep50trig,
    input  logic              reset_global,
    input  param_cmd_t        i_cmd,
    input  logic              i_cmd_valid,
    output chan_param_t       o_param_ia,
    output chan_param_t       o_param_ii,
    output logic [`POT_W-1:0] o_thresh,
    output logic              o_clear
);

    logic [`RATE_W-1:0] cmd_offset;  // command data cut to offset width
    logic [`GAIN_W-1:0] cmd_gain;

    assign cmd_offset = i_cmd.data[`RATE_W-1:0];
    assign cmd_gain   = i_cmd.data[`GAIN_W-1:0];

    // one write per command, new value visible the following cycle
    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            o_param_ia.offset <= `RATE_W'(`OFFSET_IA_RST);
            o_param_ia.gain   <= `GAIN_W'(`GAIN_IA_RST);
            o_param_ii.offset <= `RATE_W'(`OFFSET_II_RST);
            o_param_ii.gain   <= `GAIN_W'(`GAIN_II_RST);
            o_thresh          <= `POT_W'(`THRESH_RST);
            o_clear           <= 1'b0;
        end else begin
            o_clear <= 1'b0;  // clear is a single-cycle pulse
            if (i_cmd_valid) begin
                case (i_cmd.op)
                    OP_OFFSET_IA: o_param_ia.offset <= cmd_offset;
                    OP_GAIN_IA:   o_param_ia.gain   <= cmd_gain;
                    OP_OFFSET_II: o_param_ii.offset <= cmd_offset;
                    OP_GAIN_II:   o_param_ii.gain   <= cmd_gain;
                    OP_THRESH: begin
                        o_thresh <= i_cmd.data[`POT_W-1:0];  // full 24 bits
                    end
                    OP_CLEAR:     o_clear <= 1'b1;
                    default: begin
                        // OP_NOP and unused codes leave the bank alone
                    end
                endcase
            end
        end
    end

endmodule

/* src/rate_fifo.sv */
`timescale 1ns/1ps
`include "spindle_defines.svh"

module rate_fifo
    import afferent_pkg::*;
(
    input  logic         ep50trig,
    input  logic         reset_global,
    input  rate_sample_t i_sample,
    input  logic         i_sample_valid,
    output rate_sample_t o_sample,
    output logic         o_sample_valid,
    output logic         o_credit
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);  // must hold the full count

    rate_sample_t     mem [`FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;

    assign pop = (count != '0);  // drain every cycle there is data

    // head entry goes straight to the channels, credit returns with it
    assign o_sample       = mem[rd_ptr];
    assign o_sample_valid = pop;
    assign o_credit       = pop;

    // storage, written whenever the sender spends a credit
    always_ff @(posedge ep50trig) begin
        if (i_sample_valid)
            mem[wr_ptr] <= i_sample;
    end

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_sample_valid)
                wr_ptr <= (wr_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // push and pop together leave the count unchanged
            count <= count + CNT_W'(i_sample_valid) - CNT_W'(pop);
        end
    end

endmodule

/* src/afferent_channel.sv */
`timescale 1ns/1ps
`include "spindle_defines.svh"

module afferent_channel
    import afferent_pkg::*;
(
    input  logic               ep50trig,
    input  logic               reset_global,
    input  logic [`RATE_W-1:0] i_rate,
    input  logic               i_valid,
    input  chan_param_t        i_param,
    input  logic [`POT_W-1:0]  i_thresh,
    input  logic               i_clear,
    output logic               o_spike,
    output logic               o_valid
);

    localparam int PROD_W = `RATE_W + `GAIN_W;

    // stage 1 signals
    logic [`RATE_W-1:0]           diff;
    logic [PROD_W-1:0]            prod;
    logic [PROD_W-`GAIN_FRAC-1:0] scaled;
    logic [`RATE_W-1:0]           drive_next;
    logic [`RATE_W-1:0]           drive;      // registered drive
    logic                         s1_valid;

    // stage 2 signals
    logic [`POT_W-1:0] pot;                   // membrane potential
    logic [`POT_W-1:0] pot_base;
    logic [`POT_W:0]   sum;                   // one extra bit for carry
    logic [`POT_W:0]   pot_next;
    logic              fire;

    // offset removal, floored at zero
    assign diff   = (i_rate > i_param.offset) ? i_rate - i_param.offset : '0;
    assign prod   = diff * i_param.gain;
    assign scaled = prod[PROD_W-1:`GAIN_FRAC];   // drop gain fraction
    assign drive_next = (|scaled[PROD_W-`GAIN_FRAC-1:`RATE_W]) ?
                        {`RATE_W{1'b1}} : scaled[`RATE_W-1:0];  // saturate to 16 bits

    always_ff @(posedge ep50trig) begin
        drive <= drive_next;  // payload, qualified by s1_valid
    end

    // a clear in the same cycle as a sample integrates from zero
    assign pot_base = i_clear ? '0 : pot;
    assign sum      = pot_base + drive;
    assign fire     = (sum >= {1'b0, i_thresh});
    assign pot_next = fire ? sum - {1'b0, i_thresh} : sum;

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            s1_valid <= 1'b0;
            pot      <= '0;
            o_spike  <= 1'b0;
            o_valid  <= 1'b0;
        end else begin
            s1_valid <= i_valid;
            o_valid  <= s1_valid;
            o_spike  <= s1_valid & fire;  // at most one spike per sample
            if (s1_valid) begin
                // clamp at full scale instead of wrapping
                pot <= pot_next[`POT_W] ? {`POT_W{1'b1}} : pot_next[`POT_W-1:0];
            end else if (i_clear) begin
                pot <= '0;
            end
        end
    end

endmodule

/* src/spike_tally.sv */
`timescale 1ns/1ps
`include "spindle_defines.svh"

module spike_tally
    import afferent_pkg::*;
(
    input  logic         ep50trig,
    input  logic         reset_global,
    input  logic         i_spike_ia,
    input  logic         i_spike_ii,
    input  logic         i_valid,       // Ia valid, II runs in lockstep
    input  logic         i_clear,
    output spike_event_t o_event,
    output logic         o_event_valid
);

    logic [`CNT_W-1:0] count_ia;
    logic [`CNT_W-1:0] count_ii;
    logic [`CNT_W-1:0] next_ia;
    logic [`CNT_W-1:0] next_ii;

    // clear first, then count the spike of a coincident sample
    assign next_ia = (i_clear ? '0 : count_ia) + `CNT_W'(i_spike_ia);  // wraps
    assign next_ii = (i_clear ? '0 : count_ii) + `CNT_W'(i_spike_ii);

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            count_ia      <= '0;
            count_ii      <= '0;
            o_event       <= '0;
            o_event_valid <= 1'b0;
        end else begin
            o_event_valid <= i_valid;
            if (i_valid) begin
                count_ia <= next_ia;
                count_ii <= next_ii;
                o_event  <= '{spike_ia: i_spike_ia, spike_ii: i_spike_ii,
                              count_ia: next_ia, count_ii: next_ii};
            end else if (i_clear) begin
                count_ia <= '0;  // idle clear
                count_ii <= '0;
            end
        end
    end

endmodule

/* src/afferent_encoder_top.sv */
`timescale 1ns/1ps
`include "spindle_defines.svh"

module afferent_encoder_top
    import afferent_pkg::*;
(
    input  logic         ep50trig,
    input  logic         reset_global,
    input  rate_sample_t i_sample,
    input  logic         i_sample_valid,
    output logic         o_credit,
    input  param_cmd_t   i_cmd,
    input  logic         i_cmd_valid,
    output spike_event_t o_event,
    output logic         o_event_valid
);

    rate_sample_t      fifo_sample;    // popped sample
    logic              fifo_valid;
    chan_param_t       param_ia;
    chan_param_t       param_ii;
    logic [`POT_W-1:0] thresh;         // shared by both channels
    logic              clear;
    logic              spike_ia;
    logic              spike_ii;
    logic              chan_valid;

    rate_fifo u_fifo (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_sample       (i_sample),
        .i_sample_valid (i_sample_valid),
        .o_sample       (fifo_sample),
        .o_sample_valid (fifo_valid),
        .o_credit       (o_credit)
    );

    param_regs u_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_cmd        (i_cmd),
        .i_cmd_valid  (i_cmd_valid),
        .o_param_ia   (param_ia),
        .o_param_ii   (param_ii),
        .o_thresh     (thresh),
        .o_clear      (clear)
    );

    afferent_channel u_ia (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_rate       (fifo_sample.rate_ia),
        .i_valid      (fifo_valid),
        .i_param      (param_ia),
        .i_thresh     (thresh),
        .i_clear      (clear),
        .o_spike      (spike_ia),
        .o_valid      (chan_valid)
    );

    // same timing as u_ia, its valid is redundant
    afferent_channel u_ii (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_rate       (fifo_sample.rate_ii),
        .i_valid      (fifo_valid),
        .i_param      (param_ii),
        .i_thresh     (thresh),
        .i_clear      (clear),
        .o_spike      (spike_ii),
        .o_valid      ()
    );

    spike_tally u_tally (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_spike_ia    (spike_ia),
        .i_spike_ii    (spike_ii),
        .i_valid       (chan_valid),
        .i_clear       (clear),
        .o_event       (o_event),
        .o_event_valid (o_event_valid)
    );

endmodule

/* tests/afferent_encoder_assert.sv */
`timescale 1ns/1ps
`include "spindle_defines.svh"

module afferent_encoder_assert (
    input logic ep50trig,
    input logic reset_global,
    input logic i_sample_valid,
    input logic o_credit,
    input logic o_event_valid
);

    int unsigned accepted;        // samples pushed since reset
    int unsigned returned;        // credits handed back
    int unsigned fail_count = 0;  // failed assertions so far

    always_ff @(posedge ep50trig) begin
        if (reset_global) begin
            accepted <= 0;
            returned <= 0;
        end else begin
            accepted <= accepted + 32'(i_sample_valid);
            returned <= returned + 32'(o_credit);
        end
    end

    event_valid_known: assert property (@(posedge ep50trig) disable iff (reset_global)
        !$isunknown(o_event_valid))
        else begin
            fail_count++;
            $error("o_event_valid is unknown");
        end

    // a pop only returns a credit for a sample already taken
    credit_after_accept: assert property (@(posedge ep50trig) disable iff (reset_global)
        (returned + 32'(o_credit)) <= accepted)
        else begin
            fail_count++;
            $error("more credits returned than samples accepted");
        end

    held_within_depth: assert property (@(posedge ep50trig) disable iff (reset_global)
        (accepted - returned) <= `FIFO_DEPTH)
        else begin
            fail_count++;
            $error("samples held exceed the FIFO depth");
        end

endmodule

/* tests/tb_afferent_encoder.sv */
`timescale 1ns/1ps
`include "spindle_defines.svh"

module tb_afferent_encoder
    import afferent_pkg::*;
();

    localparam int N_ROWS = 10;

    logic         ep50trig;
    logic         reset_global;
    rate_sample_t i_sample;
    logic         i_sample_valid;
    logic         o_credit;
    param_cmd_t   i_cmd;
    logic         i_cmd_valid;
    spike_event_t o_event;
    logic         o_event_valid;

    // stimulus table, one entry per row
    string        row_name  [N_ROWS];
    afferent_op_e row_op    [N_ROWS];   // OP_NOP means no command
    logic [23:0]  row_data  [N_ROWS];
    int           row_count [N_ROWS];   // samples sent after the command
    bit           row_rand  [N_ROWS];
    bit           row_gaps  [N_ROWS];   // random idle cycles between samples
    rate_sample_t row_rate  [N_ROWS];

    // reference model state, index 0 is Ia and 1 is II
    logic [15:0]  mod_off  [2];
    logic [15:0]  mod_gain [2];
    logic [23:0]  mod_pot  [2];
    logic [15:0]  mod_cnt  [2];
    logic [23:0]  mod_thr;

    spike_event_t exp_q [$];            // predicted events in order
    spike_event_t exp_ev;
    string        cur_name;
    logic [31:0]  lcg_state;
    int           credits;              // sender credit counter
    int           samples_sent;
    int           credit_pulses;
    int           n_rows;
    bit           table_ready;

    afferent_encoder_top dut0 (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_sample       (i_sample),
        .i_sample_valid (i_sample_valid),
        .o_credit       (o_credit),
        .i_cmd          (i_cmd),
        .i_cmd_valid    (i_cmd_valid),
        .o_event        (o_event),
        .o_event_valid  (o_event_valid)
    );

    bind afferent_encoder_top afferent_encoder_assert u_assert (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_sample_valid (i_sample_valid),
        .o_credit       (o_credit),
        .o_event_valid  (o_event_valid)
    );

    initial begin
        ep50trig = 1'b0;
        forever #2 ep50trig = ~ep50trig;  // 4 ns period
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s, %s: expected %0d actual %0d",
                     cur_name, what, expected, actual);
            $display("Test failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic add_row(input string name, input afferent_op_e op, input logic [23:0] data,
                           input int count, input bit rnd, input bit gaps,
                           input logic [15:0] ia, input logic [15:0] ii);
        row_name[n_rows]  = name;
        row_op[n_rows]    = op;
        row_data[n_rows]  = data;
        row_count[n_rows] = count;
        row_rand[n_rows]  = rnd;
        row_gaps[n_rows]  = gaps;
        row_rate[n_rows]  = {ia, ii};
        n_rows++;
    endtask

    // one sample through one channel, straight from the arithmetic rules
    task automatic model_channel(input int ch, input logic [15:0] rate, output logic spike);
        logic [31:0] diff;
        logic [31:0] drive;
        logic [24:0] sum;
        diff  = (rate > mod_off[ch]) ? 32'(rate - mod_off[ch]) : 32'd0;
        drive = (diff * mod_gain[ch]) >> `GAIN_FRAC;
        if (drive > 32'hffff)
            drive = 32'hffff;                       // drive saturates at 16 bits
        sum   = 25'(mod_pot[ch]) + 25'(drive);
        spike = (sum >= 25'(mod_thr));
        if (spike)
            sum = sum - 25'(mod_thr);
        mod_pot[ch] = (sum > 25'hffffff) ? 24'hffffff : sum[23:0];
        mod_cnt[ch] = mod_cnt[ch] + 16'(spike);     // wraps
    endtask

    task automatic apply_cmd(input afferent_op_e op, input logic [23:0] data);
        @(posedge ep50trig);
        i_cmd       <= {op, data};
        i_cmd_valid <= 1'b1;
        @(posedge ep50trig);
        i_cmd_valid <= 1'b0;
        case (op)
            OP_OFFSET_IA: mod_off[0]  = data[15:0];
            OP_GAIN_IA:   mod_gain[0] = data[15:0];
            OP_OFFSET_II: mod_off[1]  = data[15:0];
            OP_GAIN_II:   mod_gain[1] = data[15:0];
            OP_THRESH:    mod_thr     = data;
            OP_CLEAR: begin
                mod_pot = '{24'd0, 24'd0};
                mod_cnt = '{16'd0, 16'd0};
            end
            default: ;
        endcase
    endtask

    task automatic send_sample(input rate_sample_t s, input bit gaps);
        logic [31:0]  r;
        logic         sp_ia;
        logic         sp_ii;
        spike_event_t ev;
        if (gaps) begin
            r = lcg_next();
            repeat (r[9:8]) begin
                @(posedge ep50trig);
                i_sample_valid <= 1'b0;             // sender idles
            end
        end
        @(posedge ep50trig);
        while (credits == 0) begin
            i_sample_valid <= 1'b0;                 // out of credits, hold off
            @(posedge ep50trig);
        end
        i_sample       <= s;
        i_sample_valid <= 1'b1;
        credits = credits - 1;
        samples_sent++;
        model_channel(0, s.rate_ia, sp_ia);
        model_channel(1, s.rate_ii, sp_ii);
        ev = {sp_ia, sp_ii, mod_cnt[0], mod_cnt[1]};
        exp_q.push_back(ev);
    endtask

    // wait until every event is out and every credit is back
    task automatic drain_pipeline();
        while (exp_q.size() != 0 || credits != `FIFO_DEPTH)
            @(negedge ep50trig);
    endtask

    task automatic run_row(input int r);
        rate_sample_t s;
        logic [31:0]  rnd;
        cur_name = row_name[r];
        if (row_op[r] != OP_NOP)
            apply_cmd(row_op[r], row_data[r]);
        for (int k = 0; k < row_count[r]; k++) begin
            s = row_rate[r];
            if (row_rand[r]) begin
                rnd = lcg_next();
                s.rate_ia = {4'h0, rnd[30:19]};
                s.rate_ii = {4'h0, rnd[22:11]};
            end
            send_sample(s, row_gaps[r]);
        end
        @(posedge ep50trig);
        i_sample_valid <= 1'b0;
        drain_pipeline();
    endtask

    // monitor samples outputs on the falling edge, away from the updates
    always @(negedge ep50trig) begin
        if (!reset_global) begin
            if (o_credit) begin
                credits = credits + 1;
                credit_pulses++;
            end
            if (o_event_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Event arrived in %s with no sample outstanding", cur_name);
                    $display("Test failed");
                    $fatal(1, "unexpected event");
                end else begin
                    exp_ev = exp_q.pop_front();
                    check_value("spike_ia", exp_ev.spike_ia, o_event.spike_ia);
                    check_value("spike_ii", exp_ev.spike_ii, o_event.spike_ii);
                    check_value("count_ia", exp_ev.count_ia, o_event.count_ia);
                    check_value("count_ii", exp_ev.count_ii, o_event.count_ii);
                end
            end
        end
    end

    // bound assertion failures
    always @(negedge ep50trig) begin
        if (dut0.u_assert.fail_count != 0) begin
            $display("A bound assertion failed in %s", cur_name);
            $display("Test failed");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        longint limit_ns;
        int     total;
        wait (table_ready);
        total = 0;
        for (int r = 0; r < n_rows; r++)
            total += row_count[r];
        limit_ns = (longint'(total) * 20 + 8) * 4;  // 20 cycles per sample plus reset
        #(limit_ns);
        $display("Timeout after %0d ns, %0d events never arrived", limit_ns, exp_q.size());
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        reset_global   = 1'b1;
        i_sample       = '0;
        i_sample_valid = 1'b0;
        i_cmd          = '0;
        i_cmd_valid    = 1'b0;
        lcg_state      = 32'hdbc9;
        credits        = `FIFO_DEPTH;
        samples_sent   = 0;
        credit_pulses  = 0;
        n_rows         = 0;
        cur_name       = "reset";
        mod_off  = '{16'(`OFFSET_IA_RST), 16'(`OFFSET_II_RST)};
        mod_gain = '{16'(`GAIN_IA_RST), 16'(`GAIN_II_RST)};
        mod_pot  = '{24'd0, 24'd0};
        mod_cnt  = '{16'd0, 16'd0};
        mod_thr  = 24'(`THRESH_RST);
        //      name              command       data      n   rnd gaps  Ia     II
        add_row("default_steady", OP_NOP,       24'd0,    32, 0,  0,    138,   138);
        add_row("below_offset",   OP_NOP,       24'd0,    8,  0,  0,    5,     10);
        add_row("load_offset_ia", OP_OFFSET_IA, 24'd20,   0,  0,  0,    0,     0);
        add_row("load_gain_ii",   OP_GAIN_II,   24'd512,  0,  0,  0,    0,     0);
        add_row("load_thresh",    OP_THRESH,    24'd700,  20, 0,  0,    150,   90);
        // Ia drive 65790 before the clamp, a wrapped value would sit under the threshold
        add_row("gain_saturate",  OP_GAIN_IA,   24'hffff, 10, 0,  0,    277,   200);
        add_row("clear_state",    OP_CLEAR,     24'd0,    12, 0,  0,    138,   138);
        add_row("restore_gain",   OP_GAIN_IA,   24'd256,  0,  0,  0,    0,     0);
        add_row("random_gaps",    OP_NOP,       24'd0,    64, 1,  1,    0,     0);
        add_row("random_burst",   OP_NOP,       24'd0,    64, 1,  0,    0,     0);
        table_ready = 1'b1;
        repeat (8) @(posedge ep50trig);
        reset_global <= 1'b0;
        @(negedge ep50trig);
        check_value("o_event_valid", 0, o_event_valid);
        check_value("o_credit", 0, o_credit);
        for (int r = 0; r < n_rows; r++)
            run_row(r);
        cur_name = "credit_total";
        check_value("credit pulses", samples_sent, credit_pulses);
        if (dut0.u_assert.fail_count != 0) begin
            $display("A bound assertion failed during the run");
            $display("Test failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* Bender.yml */
package:
  name: afferent_encoder

export_include_dirs:
  - include

sources:
  - src/afferent_pkg.sv
  - src/param_regs.sv
  - src/rate_fifo.sv
  - src/afferent_channel.sv
  - src/spike_tally.sv
  - src/afferent_encoder_top.sv
  - target: test
    files:
      - tests/afferent_encoder_assert.sv
      - tests/tb_afferent_encoder.sv

/* tb.f */
+incdir+include
src/afferent_pkg.sv
src/param_regs.sv
src/rate_fifo.sv
src/afferent_channel.sv
src/spike_tally.sv
src/afferent_encoder_top.sv
tests/afferent_encoder_assert.sv
tests/tb_afferent_encoder.sv
